// ==== verilog.f ====
logic/lsu_pkg.sv
logic/axi_lite_pkg.sv
logic/lsu_align.sv
logic/lsu_stbuf.sv
logic/lsu_dccm_ctl.sv
logic/lsu_bus_intf.sv
logic/lsu_pipe_ctl.sv
logic/lsu_top.sv
tests/lsu_tb_axi_slave.sv
tests/lsu_tb.sv

// ==== tests/lsu_tb.sv ====
// Testbench for the LSU top that checks random requests against a byte reference model
`timescale 1ns/1ps

module lsu_tb;
   import lsu_pkg::*;
   import axi_lite_pkg::*;

   localparam logic [31:0] DCCM_BASE  = 32'hF004_0000;
   localparam int          DCCM_WORDS = 1024;
   localparam logic [31:0] EXT_BASE   = 32'h2000_0000;
   localparam logic [31:0] ERR_WIN    = 32'h2000_0100;   // Slave answers SLVERR here
   localparam int          N_REQ      = 400;
   localparam int          LIMIT      = 40 * N_REQ + 100;

   typedef struct packed {
      logic [31:0]  data;
      lsu_err_e     err;
      logic         ext;    // Goes out on the bus
      logic [31:0]  due;    // Response cycle for non-bus ops
   } exp_t;

   logic         clk = 1'b0;
   logic         rst;
   logic         req_valid, req_ready, rsp_valid;
   lsu_req_t     req;
   lsu_rsp_t     rsp;
   logic         awvalid, awready, wvalid, wready, bvalid, bready;
   logic         arvalid, arready, rvalid, rready;
   axi_aw_t      aw;
   axi_w_t       w;
   axi_resp_e    bresp;
   axi_ar_t      ar;
   axi_r_t       r;
   logic [4:0]   stall;
   logic [7:0]   dccm_ref [4096];
   logic [7:0]   ext_ref [256];
   exp_t         exp_q [$];
   logic [15:0]  lfsr = 16'd43017;
   int           cycle, ext_out, n_acc;

   always #4 clk = ~clk;

   lsu_top #(
      .DCCM_BASE   (DCCM_BASE),
      .DCCM_WORDS  (DCCM_WORDS),
      .STBUF_DEPTH (4)
   ) uut (.*);

   lsu_tb_axi_slave #(.ERR_BASE(ERR_WIN)) slave (.*);

   task automatic stop_run();
      $display("Regression failed");
      $fatal(1);
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] pool_addr(input logic [2:0] i);
      if (i[2])
         return EXT_BASE + {i[1:0], 2'b00};
      case (i[1:0])
         2'd0:    return DCCM_BASE;
         2'd1:    return DCCM_BASE + 32'h004;
         2'd2:    return DCCM_BASE + 32'h010;
         default: return DCCM_BASE + 32'hFFC;   // Last DCCM word
      endcase
   endfunction

   function automatic logic [7:0] read_byte(input logic [31:0] a);
      return (a[31:16] == DCCM_BASE[31:16]) ? dccm_ref[a[11:0]] : ext_ref[a[7:0]];
   endfunction

   function automatic void write_byte(input logic [31:0] a, input logic [7:0] d);
      if (a[31:16] == DCCM_BASE[31:16])
         dccm_ref[a[11:0]] = d;
      else
         ext_ref[a[7:0]] = d;
   endfunction

   // Expected response with the reference memory updated in acceptance order
   function automatic exp_t predict(input lsu_req_t q, input int due);
      exp_t         e;
      logic [31:0]  a;
      logic [31:0]  v;
      int           nb;
      a  = q.base + {{20{q.offset[11]}}, q.offset};
      nb = (q.size == SZ_BYTE) ? 1 : (q.size == SZ_HALF) ? 2 : 4;
      e  = '{data: '0, err: ERR_NONE, ext: 1'b0, due: 32'(due)};
      v  = '0;
      if ((a[1:0] & 2'(nb - 1)) != 2'b00)
         e.err = ERR_MISALIGN;
      else if (a[31:16] == DCCM_BASE[31:16]) begin
         if (a[15:2] >= DCCM_WORDS)
            e.err = ERR_FAULT;
      end else begin
         e.ext = 1'b1;
         if (a[31:8] == ERR_WIN[31:8])
            e.err = ERR_BUS;
      end
      if (e.err == ERR_NONE) begin
         for (int k = 0; k < nb; k++) begin
            if (q.op == OP_STORE)
               write_byte(a + k, q.st_data[8*k +: 8]);
            else
               v[8*k +: 8] = read_byte(a + k);
         end
         if (q.op == OP_LOAD && nb < 4 && !q.unsign && v[8*nb-1])
            v = v | (32'hFFFF_FFFF << (8 * nb));   // Sign extension
         if (q.op == OP_LOAD)
            e.data = v;
      end
      return e;
   endfunction

   function automatic lsu_req_t make_req(input int n);
      lsu_req_t     q;
      logic [31:0]  a;
      logic [31:0]  off;
      logic [1:0]   lane;
      logic [3:0]   k;
      if (n < 8) begin   // Seed every pool word with a full store
         q.op     = OP_STORE;
         q.size   = SZ_WORD;
         q.unsign = 1'b0;
         a        = pool_addr(3'(n));
      end else begin
         q.op     = lsu_op_e'(take_bits(1));
         lane     = take_bits(2);
         q.size   = (lane == 2'd3) ? SZ_WORD : lsu_size_e'(lane);
         q.unsign = take_bits(1);
         k        = take_bits(4);
         if (k < 8)
            a = pool_addr({1'b0, 2'(take_bits(2))});
         else if (k < 13)
            a = pool_addr({1'b1, 2'(take_bits(2))});
         else if (k == 13)
            a = DCCM_BASE + 32'(DCCM_WORDS * 4);   // First word past the array
         else
            a = ERR_WIN + (take_bits(2) << 2);
         lane = take_bits(2);
         if (take_bits(2) != 0)   // Mostly aligned
            lane = lane & ((q.size == SZ_BYTE) ? 2'b11 : (q.size == SZ_HALF) ? 2'b10 : 2'b00);
         a = a + lane;
      end
      off       = take_bits(12);
      off       = {{20{off[11]}}, off[11:0]};
      q.offset  = off[11:0];
      q.base    = a - off;
      q.st_data = take_bits(32);
      return q;
   endfunction

   task automatic next_cycle();
      @(negedge clk);
      stall = take_bits(5);
   endtask

   // ********************
   // Response checks
   // ********************
   always @(posedge clk) begin : monitor
      exp_t e;
      if (rst) begin
         cycle   = 0;
         ext_out = 0;
         n_acc   = 0;
      end else begin
         assert (ext_out == 0 || !req_ready)
         else begin
            $display("req_ready high while an external access is outstanding");
            stop_run();
         end
         if (rsp_valid) begin
            assert (exp_q.size() != 0)
            else begin
               $display("Response arrived with no request outstanding");
               stop_run();
            end
            e = exp_q.pop_front();
            assert (rsp.err === e.err)
            else begin
               $display("Error rsp.err: got %h, expected %h", rsp.err, e.err);
               stop_run();
            end
            assert (rsp.data === e.data)
            else begin
               $display("Error rsp.data: got %h, expected %h", rsp.data, e.data);
               stop_run();
            end
            assert (e.ext || cycle == int'(e.due))
            else begin
               $display("Response came at cycle %0d instead of cycle %0d", cycle, e.due);
               stop_run();
            end
            if (e.ext)
               ext_out--;
         end
         if (req_valid && req_ready) begin
            e = predict(req, cycle + 2);
            exp_q.push_back(e);
            n_acc++;
            if (e.ext)
               ext_out++;
         end
         cycle++;
         if (cycle > LIMIT) begin
            $display("Timeout, run still busy after %0d cycles", LIMIT);
            stop_run();
         end
      end
   end

   a_aw_steady: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(aw))
      else begin
         $display("aw channel dropped or changed before its handshake");
         stop_run();
      end

   a_w_steady: assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(w))
      else begin
         $display("w channel dropped or changed before its handshake");
         stop_run();
      end

   a_ar_steady: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(ar))
      else begin
         $display("ar channel dropped or changed before its handshake");
         stop_run();
      end

   // ********************
   // Stimulus
   // ********************
   initial begin
      int gap;
      rst       = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      stall     = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      assert (!rsp_valid && !awvalid && !wvalid && !arvalid && !bready && !rready && req_ready)
      else begin
         $display("Outputs not idle after reset");
         stop_run();
      end
      for (int n = 0; n < N_REQ; n++) begin
         gap = 0;
         if (n >= 8 && take_bits(2) == 0)
            gap = int'(take_bits(2));
         req_valid = 1'b0;
         repeat (gap) next_cycle();
         req       = make_req(n);
         req_valid = 1'b1;
         do
            next_cycle();
         while (n_acc <= n);
      end
      req_valid = 1'b0;
      while (exp_q.size() != 0)
         next_cycle();
      repeat (10) next_cycle();   // Room for a stray response
      $display("Regression passed");
      $finish;
   end

endmodule

// ==== tests/lsu_tb_axi_slave.sv ====
// AXI4-Lite slave memory for the LSU testbench, with stall inputs and an error window
`timescale 1ns/1ps

module lsu_tb_axi_slave #(
   parameter logic [31:0] ERR_BASE = 32'h2000_0100   // 256-byte window answering SLVERR
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [4:0]               stall,   // aw, w, ar ready holds, then b and r delays
   input  logic                     awvalid,
   output logic                     awready,
   input  axi_lite_pkg::axi_aw_t    aw,
   input  logic                     wvalid,
   output logic                     wready,
   input  axi_lite_pkg::axi_w_t     w,
   output logic                     bvalid,
   input  logic                     bready,
   output axi_lite_pkg::axi_resp_e  bresp,
   input  logic                     arvalid,
   output logic                     arready,
   input  axi_lite_pkg::axi_ar_t    ar,
   output logic                     rvalid,
   input  logic                     rready,
   output axi_lite_pkg::axi_r_t     r
);
   import axi_lite_pkg::*;

   logic [31:0]  mem [64];
   logic         aw_got, w_got, ar_got;
   logic [31:0]  wr_addr, rd_addr;
   axi_w_t       w_q;

   function automatic logic in_err_window(input logic [31:0] a);
      return a[31:8] == ERR_BASE[31:8];
   endfunction

   // Word at 0x2000_0000 + 4*i starts with a marker of its own address
   initial begin
      for (int i = 0; i < 64; i++)
         mem[i] = 32'hC0DE_0000 | 32'(i * 4);
   end

   assign awready = ~stall[0];
   assign wready  = ~stall[1];
   assign arready = ~stall[2];

   always @(posedge clk) begin
      if (rst) begin
         aw_got <= 1'b0;
         w_got  <= 1'b0;
         ar_got <= 1'b0;
         bvalid <= 1'b0;
         rvalid <= 1'b0;
         bresp  <= AXI_OKAY;
         r      <= '0;
      end else begin
         if (awvalid && awready) begin
            aw_got  <= 1'b1;
            wr_addr <= aw.addr;
         end
         if (wvalid && wready) begin
            w_got <= 1'b1;
            w_q   <= w;
         end
         // ********************
         // Write response once both halves are in
         // ********************
         if (aw_got && w_got && !bvalid && !stall[3]) begin
            bvalid <= 1'b1;
            bresp  <= in_err_window(wr_addr) ? AXI_SLVERR : AXI_OKAY;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            for (int b = 0; b < 4; b++) begin
               if (w_q.strb[b] && !in_err_window(wr_addr))
                  mem[wr_addr[7:2]][8*b +: 8] <= w_q.data[8*b +: 8];
            end
         end
         if (bvalid && bready)
            bvalid <= 1'b0;
         // ********************
         // Read path
         // ********************
         if (arvalid && arready) begin
            ar_got  <= 1'b1;
            rd_addr <= ar.addr;
         end
         if (ar_got && !rvalid && !stall[4]) begin
            rvalid <= 1'b1;
            ar_got <= 1'b0;
            r.data <= in_err_window(rd_addr) ? 32'hDEAD_BEEF : mem[rd_addr[7:2]];
            r.resp <= in_err_window(rd_addr) ? AXI_SLVERR : AXI_OKAY;
         end
         if (rvalid && rready)
            rvalid <= 1'b0;
      end
   end

endmodule

// ==== logic/lsu_top.sv ====
// Load/store unit top level, connects pipeline, store buffer, DCCM and AXI4-Lite master
`timescale 1ns/1ps

module lsu_top #(
   parameter logic [31:0] DCCM_BASE   = 32'hF004_0000,
   parameter int          DCCM_WORDS  = 1024,
   parameter int          STBUF_DEPTH = 4
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     req_valid,
   input  lsu_pkg::lsu_req_t        req,
   output logic                     req_ready,
   output logic                     rsp_valid,
   output lsu_pkg::lsu_rsp_t        rsp,
   output logic                     awvalid,
   input  logic                     awready,
   output axi_lite_pkg::axi_aw_t    aw,
   output logic                     wvalid,
   input  logic                     wready,
   output axi_lite_pkg::axi_w_t     w,
   input  logic                     bvalid,
   output logic                     bready,
   input  axi_lite_pkg::axi_resp_e  bresp,
   output logic                     arvalid,
   input  logic                     arready,
   output axi_lite_pkg::axi_ar_t    ar,
   input  logic                     rvalid,
   output logic                     rready,
   input  axi_lite_pkg::axi_r_t     r
);
   import lsu_pkg::*;

   logic                           dc1_rd_en;
   logic [$clog2(DCCM_WORDS)-1:0]  dc1_word;
   lsu_pkt_t                       dc2_pkt, dc3_pkt;
   logic [XLEN-1:0]                dc2_word_data, fwd_data, bus_data;
   logic [BYTES-1:0]               fwd_be;
   logic                           stbuf_push, stbuf_full;
   stbuf_entry_t                   stbuf_entry, drain_entry;
   logic                           drain_valid, drain_done;
   logic                           bus_start, bus_done;
   lsu_err_e                       bus_err;

   lsu_pipe_ctl #(
      .DCCM_BASE  (DCCM_BASE),
      .DCCM_WORDS (DCCM_WORDS)
   ) u_pipe (.*);

   lsu_stbuf #(.STBUF_DEPTH(STBUF_DEPTH)) u_stbuf (
      .clk, .rst,
      .push       (stbuf_push),
      .push_entry (stbuf_entry),
      .full       (stbuf_full),
      .dc2_pkt, .fwd_data, .fwd_be, .drain_valid, .drain_entry, .drain_done
   );

   lsu_dccm_ctl #(.DCCM_WORDS(DCCM_WORDS)) u_dccm (
      .clk, .rst,
      .rd_en   (dc1_rd_en),
      .rd_word (dc1_word),
      .drain_valid, .drain_entry, .drain_done, .fwd_data, .fwd_be, .dc2_word_data
   );

   lsu_bus_intf u_bus (
      .clk, .rst,
      .start   (bus_start),
      .pkt     (dc3_pkt),
      .done    (bus_done),
      .rd_data (bus_data),
      .err     (bus_err),
      .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .bready, .bresp,
      .arvalid, .arready, .ar, .rvalid, .rready, .r
   );

endmodule

// ==== logic/lsu_pipe_ctl.sv ====
// DC1 to DC3 pipeline control, address and region decode, ready and response generation
`timescale 1ns/1ps

module lsu_pipe_ctl #(
   parameter logic [31:0] DCCM_BASE  = 32'hF004_0000,
   parameter int          DCCM_WORDS = 1024
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           req_valid,
   input  lsu_pkg::lsu_req_t              req,
   output logic                           req_ready,
   output logic                           rsp_valid,
   output lsu_pkg::lsu_rsp_t              rsp,
   output logic                           dc1_rd_en,
   output logic [$clog2(DCCM_WORDS)-1:0]  dc1_word,
   output lsu_pkg::lsu_pkt_t              dc2_pkt,
   input  logic [lsu_pkg::XLEN-1:0]       dc2_word_data,
   output logic                           stbuf_push,
   output lsu_pkg::stbuf_entry_t          stbuf_entry,
   input  logic                           stbuf_full,
   output logic                           bus_start,
   output lsu_pkg::lsu_pkt_t              dc3_pkt,
   input  logic                           bus_done,
   input  logic [lsu_pkg::XLEN-1:0]       bus_data,
   input  lsu_pkg::lsu_err_e              bus_err
);
   import lsu_pkg::*;

   localparam int IDX_W = $clog2(DCCM_WORDS);

   lsu_pkt_t          dc1, dc2_q, dc3_q;
   logic [XLEN-1:0]   dc1_addr;
   logic [XLEN-1:0]   ld_word_q;   // DCCM word latched at end of DC2
   logic [XLEN-1:0]   st_word, ld_data;
   logic [BYTES-1:0]  st_be;
   logic              dc3_ext, dc3_hold, bus_pend;
   lsu_err_e          dc3_err;

   function automatic logic misaligned(lsu_size_e size, logic [1:0] off);
      return (size == SZ_HALF && off[0]) || (size == SZ_WORD && off != 2'b00);
   endfunction

   // ********************
   // DC1
   // ********************
   assign dc1_addr = req.base + {{20{req.offset[11]}}, req.offset};

   always_comb begin
      dc1.valid  = req_valid & req_ready;
      dc1.op     = req.op;
      dc1.size   = req.size;
      dc1.unsign = req.unsign;
      dc1.addr   = dc1_addr;
      dc1.data   = req.st_data;   // Lanes placed in DC3
      dc1.be     = '0;
      if (misaligned(req.size, dc1_addr[1:0]))
         dc1.region = REG_FAULT;
      else if (dc1_addr[31:16] != DCCM_BASE[31:16])
         dc1.region = REG_EXT;
      else if ({18'b0, dc1_addr[15:2]} >= DCCM_WORDS)
         dc1.region = REG_FAULT;   // Past the end of the array
      else
         dc1.region = REG_DCCM;
   end

   assign dc1_rd_en = dc1.valid & (dc1.op == OP_LOAD) & (dc1.region == REG_DCCM);
   assign dc1_word  = dc1_addr[IDX_W+1:2];

   // Blocking bus ops stall intake until they leave DC3
   assign req_ready = ~((dc2_q.valid & (dc2_q.region == REG_EXT)) | dc3_ext) & ~stbuf_full;

   // ********************
   // Stage registers
   // ********************
   always_ff @(posedge clk) begin
      if (rst) begin
         dc2_q    <= '0;
         dc3_q    <= '0;
         bus_pend <= 1'b0;
      end else begin
         dc2_q <= dc1;
         if (!dc3_hold)
            dc3_q <= dc2_q;
         bus_pend <= bus_start | (bus_pend & ~bus_done);
      end
   end

   always_ff @(posedge clk) begin
      if (!dc3_hold)
         ld_word_q <= dc2_word_data;
   end

   assign dc2_pkt = dc2_q;

   // ********************
   // DC3
   // ********************
   assign dc3_ext   = dc3_q.valid & (dc3_q.region == REG_EXT);
   assign dc3_hold  = dc3_ext & ~bus_done;
   assign bus_start = dc3_ext & ~bus_pend;   // One access per op

   lsu_align u_align (
      .size        (dc3_q.size),
      .unsigned_ld (dc3_q.unsign),
      .byte_off    (dc3_q.addr[1:0]),
      .st_data     (dc3_q.data),
      .st_word     (st_word),
      .st_be       (st_be),
      .ld_word     (dc3_ext ? bus_data : ld_word_q),
      .ld_data     (ld_data)
   );

   always_comb begin
      dc3_pkt      = dc3_q;
      dc3_pkt.data = st_word;
      dc3_pkt.be   = st_be;
   end

   assign stbuf_push  = dc3_q.valid & (dc3_q.op == OP_STORE) & (dc3_q.region == REG_DCCM);
   assign stbuf_entry = '{waddr: dc3_q.addr[31:2], data: st_word, be: st_be};

   always_comb begin
      if (misaligned(dc3_q.size, dc3_q.addr[1:0]))
         dc3_err = ERR_MISALIGN;
      else if (dc3_q.region == REG_FAULT)
         dc3_err = ERR_FAULT;
      else if (dc3_ext)
         dc3_err = bus_err;
      else
         dc3_err = ERR_NONE;
   end

   assign rsp_valid = dc3_q.valid & (~dc3_ext | bus_done);
   assign rsp.err   = dc3_err;
   assign rsp.data  = (dc3_q.op == OP_LOAD && dc3_err == ERR_NONE) ? ld_data : '0;

   // Stores reach DC3 two cycles after acceptance
   a_push_room: assert property (@(posedge clk) disable iff (rst)
      stbuf_push |-> $past(!stbuf_full, 2))
      else $error("store pushed without room reserved at acceptance");

   a_dc3_stable: assert property (@(posedge clk) disable iff (rst)
      bus_pend && !bus_done |=> $stable(dc3_q))
      else $error("DC3 packet changed during bus access");

endmodule

// ==== logic/lsu_bus_intf.sv ====
// AXI4-Lite master, runs one blocking read or write per start
`timescale 1ns/1ps

module lsu_bus_intf (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  lsu_pkg::lsu_pkt_t        pkt,
   output logic                     done,
   output logic [lsu_pkg::XLEN-1:0] rd_data,
   output lsu_pkg::lsu_err_e        err,
   output logic                     awvalid,
   input  logic                     awready,
   output axi_lite_pkg::axi_aw_t    aw,
   output logic                     wvalid,
   input  logic                     wready,
   output axi_lite_pkg::axi_w_t     w,
   input  logic                     bvalid,
   output logic                     bready,
   input  axi_lite_pkg::axi_resp_e  bresp,
   output logic                     arvalid,
   input  logic                     arready,
   output axi_lite_pkg::axi_ar_t    ar,
   input  logic                     rvalid,
   output logic                     rready,
   input  axi_lite_pkg::axi_r_t     r
);
   import lsu_pkg::*;
   import axi_lite_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_ADDR,
      S_RESP,
      S_DONE
   } state_e;

   state_e    state;
   lsu_pkt_t  pkt_q;
   logic      is_wr;
   logic      aw_ok, w_ok;   // Write channels accepted so far

   assign is_wr   = (pkt_q.op == OP_STORE);
   assign awvalid = (state == S_ADDR) & is_wr & ~aw_ok;
   assign wvalid  = (state == S_ADDR) & is_wr & ~w_ok;
   assign arvalid = (state == S_ADDR) & ~is_wr;
   assign bready  = (state == S_RESP) & is_wr;
   assign rready  = (state == S_RESP) & ~is_wr;
   assign done    = (state == S_DONE);

   assign aw = '{addr: {pkt_q.addr[31:2], 2'b00}, prot: 3'b000};
   assign ar = '{addr: {pkt_q.addr[31:2], 2'b00}, prot: 3'b000};
   assign w  = '{data: pkt_q.data, strb: pkt_q.be};

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         aw_ok <= 1'b0;
         w_ok  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               aw_ok <= 1'b0;
               w_ok  <= 1'b0;
               if (start)
                  state <= S_ADDR;
            end
            S_ADDR: begin
               aw_ok <= aw_ok | (awvalid & awready);
               w_ok  <= w_ok | (wvalid & wready);
               if (is_wr ? ((aw_ok | awready) & (w_ok | wready)) : arready)
                  state <= S_RESP;
            end
            S_RESP: begin
               if ((bvalid & bready) | (rvalid & rready))
                  state <= S_DONE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Response sampled every RESP cycle, last one is the handshake
   always_ff @(posedge clk) begin
      if (state == S_IDLE && start)
         pkt_q <= pkt;
      if (state == S_RESP) begin
         rd_data <= r.data;
         err     <= ((is_wr ? bresp : r.resp) == AXI_OKAY) ? ERR_NONE : ERR_BUS;
      end
   end

   // ********************
   // Assertions
   // ********************
   a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(aw))
      else $error("aw payload changed before handshake");

   a_w_hold: assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(w))
      else $error("w payload changed before handshake");

   a_ar_hold: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(ar))
      else $error("ar payload changed before handshake");

   a_start_idle: assert property (@(posedge clk) disable iff (rst)
      start |-> state == S_IDLE)
      else $error("bus start while an access is in progress");

endmodule

// ==== logic/lsu_dccm_ctl.sv ====
// Single-port DCCM array with read priority over store buffer drain
`timescale 1ns/1ps

module lsu_dccm_ctl #(
   parameter int DCCM_WORDS = 1024
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           rd_en,
   input  logic [$clog2(DCCM_WORDS)-1:0]  rd_word,
   input  logic                           drain_valid,
   input  lsu_pkg::stbuf_entry_t          drain_entry,
   output logic                           drain_done,
   input  logic [lsu_pkg::XLEN-1:0]       fwd_data,
   input  logic [lsu_pkg::BYTES-1:0]      fwd_be,
   output logic [lsu_pkg::XLEN-1:0]       dc2_word_data
);
   import lsu_pkg::*;

   localparam int IDX_W = $clog2(DCCM_WORDS);

   logic [XLEN-1:0]   mem [DCCM_WORDS];
   logic [XLEN-1:0]   rd_q;      // Read data in DC2
   logic [IDX_W-1:0]  wr_word;

   assign drain_done = drain_valid & ~rd_en;   // Drain takes idle port cycles
   assign wr_word    = drain_entry.waddr[IDX_W-1:0];

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_q <= mem[rd_word];
      end else if (drain_valid) begin
         for (int b = 0; b < BYTES; b++) begin
            if (drain_entry.be[b])
               mem[wr_word][8*b +: 8] <= drain_entry.data[8*b +: 8];
         end
      end
   end

   // Newer buffered bytes override the array
   always_comb begin
      for (int b = 0; b < BYTES; b++)
         dc2_word_data[8*b +: 8] = fwd_be[b] ? fwd_data[8*b +: 8] : rd_q[8*b +: 8];
   end

   // A drain pushed back by a read stays at the buffer head
   a_drain_wait: assert property (@(posedge clk) disable iff (rst)
      drain_valid && rd_en |=> drain_valid)
      else $error("blocked drain lost");

endmodule

// ==== logic/lsu_stbuf.sv ====
// Committed store FIFO in front of the DCCM with byte-wise forwarding to DC2 loads
`timescale 1ns/1ps

module lsu_stbuf #(
   parameter int STBUF_DEPTH = 4   // Power of two
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       push,
   input  lsu_pkg::stbuf_entry_t      push_entry,
   output logic                       full,
   input  lsu_pkg::lsu_pkt_t          dc2_pkt,
   output logic [lsu_pkg::XLEN-1:0]   fwd_data,
   output logic [lsu_pkg::BYTES-1:0]  fwd_be,
   output logic                       drain_valid,
   output lsu_pkg::stbuf_entry_t      drain_entry,
   input  logic                       drain_done
);
   import lsu_pkg::*;

   localparam int PTR_W = $clog2(STBUF_DEPTH);
   localparam int CNT_W = $clog2(STBUF_DEPTH + 1);

   stbuf_entry_t      ent_q [STBUF_DEPTH];
   logic [PTR_W-1:0]  wr_ptr, rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              dc2_ld, dc2_st;

   assign dc2_ld = dc2_pkt.valid & (dc2_pkt.op == OP_LOAD) & (dc2_pkt.region == REG_DCCM);
   assign dc2_st = dc2_pkt.valid & (dc2_pkt.op == OP_STORE) & (dc2_pkt.region == REG_DCCM);

   // Full counts the stores already in DC2 and DC3
   assign full = (int'(count) + int'(push) + int'(dc2_st)) >= STBUF_DEPTH;

   assign drain_valid = (count != '0);
   assign drain_entry = ent_q[rd_ptr];

   always_ff @(posedge clk) begin
      if (push)
         ent_q[wr_ptr] <= push_entry;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (drain_done)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + CNT_W'(push) - CNT_W'(drain_done);
      end
   end

   // ********************
   // Forwarding
   // ********************
   // Oldest to newest so the latest byte wins, DC3 store last
   always_comb begin
      stbuf_entry_t cand;
      logic         hit;
      fwd_data = '0;
      fwd_be   = '0;
      for (int i = 0; i <= STBUF_DEPTH; i++) begin
         if (i < STBUF_DEPTH) begin
            cand = ent_q[rd_ptr + PTR_W'(i)];
            hit  = i < int'(count);
         end else begin
            cand = push_entry;
            hit  = push;
         end
         if (dc2_ld && hit && cand.waddr == dc2_pkt.addr[31:2]) begin
            for (int b = 0; b < BYTES; b++) begin
               if (cand.be[b]) begin
                  fwd_data[8*b +: 8] = cand.data[8*b +: 8];
                  fwd_be[b]          = 1'b1;
               end
            end
         end
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
      drain_done |-> count != '0)
      else $error("store buffer drained while empty");

endmodule

// ==== logic/lsu_align.sv ====
// Store lane placement and load extraction with sign or zero extension
`timescale 1ns/1ps

module lsu_align (
   input  lsu_pkg::lsu_size_e         size,
   input  logic                       unsigned_ld,
   input  logic [1:0]                 byte_off,
   input  logic [lsu_pkg::XLEN-1:0]   st_data,
   output logic [lsu_pkg::XLEN-1:0]   st_word,
   output logic [lsu_pkg::BYTES-1:0]  st_be,
   input  logic [lsu_pkg::XLEN-1:0]   ld_word,
   output logic [lsu_pkg::XLEN-1:0]   ld_data
);
   import lsu_pkg::*;

   logic [XLEN-1:0] ld_shift;

   assign st_word  = st_data << {byte_off, 3'b000};   // Lanes above the size are masked by be
   assign ld_shift = ld_word >> {byte_off, 3'b000};

   always_comb begin
      case (size)
         SZ_BYTE: st_be = BYTES'(1) << byte_off;
         SZ_HALF: st_be = BYTES'(3) << byte_off;
         default: st_be = '1;
      endcase
   end

   always_comb begin
      case (size)
         SZ_BYTE: ld_data = {{24{~unsigned_ld & ld_shift[7]}}, ld_shift[7:0]};
         SZ_HALF: ld_data = {{16{~unsigned_ld & ld_shift[15]}}, ld_shift[15:0]};
         default: ld_data = ld_word;
      endcase
   end

endmodule

// ==== logic/axi_lite_pkg.sv ====
// AXI4-Lite channel payloads, imported by the bus master and the slave model
package axi_lite_pkg;

   typedef enum logic [1:0] {
      AXI_OKAY   = 2'b00,
      AXI_EXOKAY = 2'b01,
      AXI_SLVERR = 2'b10,
      AXI_DECERR = 2'b11
   } axi_resp_e;

   typedef struct packed {
      logic [31:0]  addr;
      logic [2:0]   prot;
   } axi_aw_t;

   typedef struct packed {
      logic [31:0]  addr;
      logic [2:0]   prot;
   } axi_ar_t;

   typedef struct packed {
      logic [31:0]  data;
      logic [3:0]   strb;
   } axi_w_t;

   typedef struct packed {
      logic [31:0]  data;
      axi_resp_e    resp;
   } axi_r_t;

endpackage

// ==== logic/lsu_pkg.sv ====
// Load/store pipeline types shared by the LSU modules and the testbench
package lsu_pkg;

   localparam int XLEN  = 32;
   localparam int BYTES = XLEN / 8;

   typedef enum logic {
      OP_LOAD  = 1'b0,
      OP_STORE = 1'b1
   } lsu_op_e;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_e;

   typedef enum logic [1:0] {
      ERR_NONE     = 2'd0,
      ERR_MISALIGN = 2'd1,
      ERR_FAULT    = 2'd2,
      ERR_BUS      = 2'd3
   } lsu_err_e;

   typedef enum logic [1:0] {
      REG_DCCM  = 2'd0,
      REG_EXT   = 2'd1,
      REG_FAULT = 2'd2   // Also used for misaligned ops
   } lsu_region_e;

   typedef struct packed {
      lsu_op_e          op;
      lsu_size_e        size;
      logic             unsign;
      logic [XLEN-1:0]  base;
      logic [11:0]      offset;
      logic [XLEN-1:0]  st_data;
   } lsu_req_t;

   typedef struct packed {
      logic              valid;
      lsu_op_e           op;
      lsu_size_e         size;
      logic              unsign;
      logic [XLEN-1:0]   addr;
      lsu_region_e       region;
      logic [XLEN-1:0]   data;
      logic [BYTES-1:0]  be;
   } lsu_pkt_t;

   typedef struct packed {
      logic [XLEN-1:0]  data;
      lsu_err_e         err;
   } lsu_rsp_t;

   typedef struct packed {
      logic [XLEN-3:0]   waddr;   // Word address
      logic [XLEN-1:0]   data;
      logic [BYTES-1:0]  be;
   } stbuf_entry_t;

endpackage
